// ==== dmgClockReset.f ====
+incdir+include
hdl/clockPkg.sv
hdl/phaseIf.sv
hdl/clockCtrlRegs.sv
hdl/phaseDivider.sv
hdl/resetSequencer.sv
hdl/dmgClockReset.sv
testbench/tbDmgClockReset.sv

// ==== hdl/clockCtrlRegs.sv ====
// Control register block for oscillator enable, clock enable and stable delay
`timescale 1ns/1ps
`include "clockGen_defs.svh"

module clockCtrlRegs (
	input  logic              clk,
	input  logic              arstN,
	input  logic              regWrite,
	input  logic              regAddr,
	input  clockPkg::regWord_u regWdata,
	input  logic              oscStable,
	output clockPkg::regWord_u regRdata,
	output logic              oscEna,
	output logic              clkEna,
	output logic [7:0]        stableDelay
);

	import clockPkg::*;

	logic ctrlWrite;
	logic delayWrite;

	assign ctrlWrite  = regWrite && (regAddr == `REG_CTRL);
	assign delayWrite = regWrite && (regAddr == `REG_DELAY);

	// Control word, decoded through the ctrl view
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			oscEna <= 1'b0;
			clkEna <= 1'b0;
		end else if (ctrlWrite) begin
			oscEna <= regWdata.ctrl.oscEna;
			// No bus clocks without a running oscillator
			clkEna <= regWdata.ctrl.clkEna & regWdata.ctrl.oscEna;
		end
	end

	// Delay count, decoded through the delay view
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stableDelay <= `DELAY_RESET;
		end else if (delayWrite) begin
			stableDelay <= regWdata.delay;
		end
	end

	// Readback, no latency
	always_comb begin
		regRdata = '0;
		if (regAddr == `REG_CTRL) begin
			regRdata.ctrl.oscEna = oscEna;
			regRdata.ctrl.clkEna = clkEna;
			regRdata.ctrl.stable = oscStable;   // Live status from the sequencer
		end else begin
			regRdata.delay = stableDelay;
		end
	end

	// Clock enable only comes up together with or after the oscillator
	aClkEnaNeedsOsc : assert property (
		@(posedge clk) disable iff (!arstN)
		$rose(clkEna) |-> oscEna
	) else $error("clkEna rose while oscEna is low");

endmodule

// ==== hdl/clockPkg.sv ====
// Clock unit package with the register word type shared by registers and top level
package clockPkg;

	// Control register layout, MSB first
	typedef struct packed {
		logic       stable;   // Bit 7, read-only
		logic [4:0] rsvd;     // Reads as zero
		logic       clkEna;   // Bit 1
		logic       oscEna;   // Bit 0
	} ctrlView_s;

	// One register byte seen either as control bits or as a delay count.
	// Which view applies depends on the register address
	typedef union packed {
		ctrlView_s  ctrl;
		logic [7:0] delay;   // Machine cycles until the oscillator is stable
	} regWord_u;

endpackage

// ==== hdl/dmgClockReset.sv ====
// Clock and reset unit top: registers, phase divider and reset sequencer on plain ports
`timescale 1ns/1ps

module dmgClockReset (
	input  logic       clk,
	input  logic       arstN,
	input  logic       regWrite,
	input  logic       regAddr,
	input  logic [7:0] regWdata,
	output logic [7:0] regRdata,
	output logic       mainTick,
	output logic       latchPhase,
	output logic       addrValid,
	output logic       dataPhase,
	output logic       incPhase,
	output logic       oscStable,
	output logic       syncReset
);

	import clockPkg::*;

	regWord_u   wdataWord;
	regWord_u   rdataWord;
	logic       oscEna;
	logic       clkEna;
	logic [7:0] stableDelay;

	phaseIf ph ();

	assign wdataWord = regWdata;   // Byte to union
	assign regRdata  = rdataWord;

	clockCtrlRegs u_clockCtrlRegs (
		.clk         (clk),
		.arstN       (arstN),
		.regWrite    (regWrite),
		.regAddr     (regAddr),
		.regWdata    (wdataWord),
		.oscStable   (oscStable),
		.regRdata    (rdataWord),
		.oscEna      (oscEna),
		.clkEna      (clkEna),
		.stableDelay (stableDelay)
	);

	phaseDivider u_phaseDivider (
		.clk    (clk),
		.arstN  (arstN),
		.oscEna (oscEna),
		.clkEna (clkEna),
		.ph     (ph.gen)
	);

	resetSequencer u_resetSequencer (
		.clk         (clk),
		.arstN       (arstN),
		.oscEna      (oscEna),
		.clkEna      (clkEna),
		.stableDelay (stableDelay),
		.ph          (ph.user),
		.oscStable   (oscStable),
		.syncReset   (syncReset)
	);

	// Phases out to the pins
	assign mainTick   = ph.mainTick;
	assign latchPhase = ph.latchPhase;
	assign addrValid  = ph.addrValid;
	assign dataPhase  = ph.dataPhase;
	assign incPhase   = ph.incPhase;

endmodule

// ==== hdl/phaseDivider.sv ====
// Phase divider splitting the master clock into four-clock machine cycles
`timescale 1ns/1ps
`include "clockGen_defs.svh"

module phaseDivider (
	input  logic clk,
	input  logic arstN,
	input  logic oscEna,
	input  logic clkEna,
	phaseIf.gen  ph
);

	localparam int PhaseW = $clog2(`MCYCLE_LEN);
	localparam logic [PhaseW-1:0] LastIdx = PhaseW'(`MCYCLE_LEN - 1);

	logic [PhaseW-1:0] phaseIdx;
	logic [PhaseW-1:0] nextIdx;
	logic              busEna;

	// Counter freezes while the oscillator is stopped
	always_comb begin
		nextIdx = phaseIdx;
		if (oscEna) begin
			nextIdx = (phaseIdx == LastIdx) ? '0 : phaseIdx + 1'b1;
		end
	end

	assign busEna = oscEna & clkEna;   // Bus phases need both enables

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			phaseIdx <= '0;
		end else begin
			phaseIdx <= nextIdx;
		end
	end

	// Outputs decoded from the next index so they line up with phaseIdx
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ph.mainTick   <= 1'b0;
			ph.latchPhase <= 1'b0;
			ph.addrValid  <= 1'b0;
			ph.dataPhase  <= 1'b0;
			ph.incPhase   <= 1'b0;
		end else begin
			ph.mainTick   <= oscEna && (nextIdx == '0);
			ph.latchPhase <= busEna && (nextIdx == PhaseW'(1));
			ph.addrValid  <= busEna && (nextIdx != '0);
			ph.dataPhase  <= busEna && (nextIdx >= PhaseW'(2));
			ph.incPhase   <= busEna && (nextIdx == LastIdx);
		end
	end

	// No second tick inside one machine cycle
	aTickGap : assert property (
		@(posedge clk) disable iff (!arstN)
		ph.mainTick |=> !ph.mainTick [*(`MCYCLE_LEN - 1)]
	) else $error("mainTick repeated within a machine cycle");

	// A running oscillator always brings the next tick
	aTickPeriod : assert property (
		@(posedge clk) disable iff (!arstN)
		(ph.mainTick && oscEna) ##1 oscEna [*(`MCYCLE_LEN - 1)] |=> ph.mainTick
	) else $error("mainTick missing after a full machine cycle");

	aDataInAddr : assert property (
		@(posedge clk) disable iff (!arstN)
		ph.dataPhase |-> ph.addrValid
	) else $error("dataPhase outside addrValid");

endmodule

// ==== hdl/phaseIf.sv ====
// Machine-cycle phase bundle from the phase divider to its users
`timescale 1ns/1ps

interface phaseIf;

	logic mainTick;     // One clock per machine cycle, phase 0
	logic latchPhase;   // Phase 1
	logic addrValid;    // Phases 1 to 3
	logic dataPhase;    // Phases 2 and 3
	logic incPhase;     // Phase 3

	modport gen (
		output mainTick,
		output latchPhase,
		output addrValid,
		output dataPhase,
		output incPhase
	);

	modport user (
		input mainTick,
		input latchPhase,
		input addrValid,
		input dataPhase,
		input incPhase
	);

endinterface

// ==== hdl/resetSequencer.sv ====
// Reset sequencer with oscillator-stable timer and CPU reset release on a cycle boundary
`timescale 1ns/1ps

module resetSequencer (
	input  logic       clk,
	input  logic       arstN,
	input  logic       oscEna,
	input  logic       clkEna,
	input  logic [7:0] stableDelay,
	phaseIf.user       ph,
	output logic       oscStable,
	output logic       syncReset
);

	logic       timerRun;   // Counting machine cycles toward stable
	logic [7:0] cycleCnt;   // Ticks still to go
	logic       startTick;
	logic       runTick;
	logic       shortDelay;

	// First tick with both enables starts the timer
	assign startTick  = ph.mainTick && oscEna && clkEna && !timerRun && !oscStable;
	assign runTick    = ph.mainTick && timerRun;
	assign shortDelay = (stableDelay <= 8'd1);   // Load tick alone is enough

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			timerRun  <= 1'b0;
			cycleCnt  <= '0;
			oscStable <= 1'b0;
		end else if (!oscEna) begin
			// Oscillator stopped, start over
			timerRun  <= 1'b0;
			cycleCnt  <= '0;
			oscStable <= 1'b0;
		end else if (startTick) begin
			if (shortDelay) begin
				oscStable <= 1'b1;
			end else begin
				timerRun <= 1'b1;
				cycleCnt <= stableDelay - 8'd1;   // Load tick counts as the first
			end
		end else if (runTick) begin
			if (cycleCnt == 8'd1) begin
				timerRun  <= 1'b0;
				oscStable <= 1'b1;
			end
			cycleCnt <= cycleCnt - 8'd1;
		end
	end

	// CPU reset drops on the tick after the stable flag, one full cycle later
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			syncReset <= 1'b1;
		end else if (!oscEna) begin
			syncReset <= 1'b1;
		end else if (oscStable && ph.mainTick) begin
			syncReset <= 1'b0;
		end
	end

	// Release only on a machine-cycle boundary
	aReleaseOnTick : assert property (
		@(posedge clk) disable iff (!arstN)
		$fell(syncReset) |-> $past(ph.mainTick)
	) else $error("syncReset released off a mainTick");

endmodule

// ==== include/clockGen_defs.svh ====
// Clock and reset unit constants: machine cycle, register map and control bits
`ifndef CLOCKGEN_DEFS_SVH
`define CLOCKGEN_DEFS_SVH

// Master clocks per machine cycle (4 MHz in, 1 MHz out)
`define MCYCLE_LEN 4

// Register map, one address bit
`define REG_CTRL  1'b0
`define REG_DELAY 1'b1

// Bit positions inside the control word
`define CTRL_OSC_ENA 0
`define CTRL_CLK_ENA 1
`define CTRL_STABLE  7   // Read-only, reflects oscStable

// Stable delay after reset, in machine cycles
`define DELAY_RESET 8'd8

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the clock and reset testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f dmgClockReset.f --top-module tbDmgClockReset \
	-o simTb > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/simTb > sim.log 2>&1 || echo "Simulator returned an error status"

grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" || {
	echo "Simulation failed, see sim.log"
	exit 1
}

// ==== testbench/tbDmgClockReset.sv ====
// Testbench for the clock and reset unit, table of register steps checked against a timing model
`timescale 1ns/1ps
`include "clockGen_defs.svh"

module tbDmgClockReset;

	import clockPkg::*;

	localparam int StepCnt     = 10;
	localparam int ResetCycles = 16;

	// One row: register write, run length in machine cycles, expected results
	typedef struct packed {
		logic     wrAddr;
		regWord_u wrData;
		logic     randDelay;    // Write a random delay instead of wrData
		logic     checkEdges;   // Compare stable and reset edges with the model
		int       runLen;
		regWord_u expRdata;
		logic     expStable;
		logic     expReset;
		int       nTick;
		int       nLatch;
		int       nAddr;
		int       nData;
		int       nInc;
	} step_s;

	logic       clk;
	logic       arstN;
	logic       regWrite;
	logic       regAddr;
	logic [7:0] regWdata;
	logic [7:0] regRdata;
	logic       mainTick;
	logic       latchPhase;
	logic       addrValid;
	logic       dataPhase;
	logic       incPhase;
	logic       oscStable;
	logic       syncReset;

	step_s    steps [StepCnt];
	int       cycleCnt;
	int       timeoutLimit;
	int       wdCycles;
	int       errWord;
	int       errBit;
	int       errCount;
	logic     counting;
	int       cntTick;
	int       cntLatch;
	int       cntAddr;
	int       cntData;
	int       cntInc;
	regWord_u smpRdata;
	logic     smpStable;
	logic     smpReset;
	logic     prevStable;
	logic     prevReset;
	int       actStableEdge;   // Clock where oscStable last changed
	int       actResetEdge;

	// Reference model state
	int   mIdx;
	logic mOsc;
	logic mClk;
	logic mTick;
	logic mStable;
	logic mReset;
	logic mRun;
	int   mDelay;
	int   mSeen;         // Ticks counted since the load, load included
	int   mStableEdge;
	int   mResetEdge;

	dmgClockReset u_dmgClockReset (
		.clk        (clk),
		.arstN      (arstN),
		.regWrite   (regWrite),
		.regAddr    (regAddr),
		.regWdata   (regWdata),
		.regRdata   (regRdata),
		.mainTick   (mainTick),
		.latchPhase (latchPhase),
		.addrValid  (addrValid),
		.dataPhase  (dataPhase),
		.incPhase   (incPhase),
		.oscStable  (oscStable),
		.syncReset  (syncReset)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;   // 100 ns period
	end

	function automatic regWord_u ctrlWord(input logic osc, input logic clkOn, input logic stb);
		regWord_u w;
		w = '0;
		w.ctrl.oscEna = osc;
		w.ctrl.clkEna = clkOn;
		w.ctrl.stable = stb;
		return w;
	endfunction

	function automatic regWord_u delayWord(input int d);
		regWord_u w;
		w.delay = 8'(d);
		return w;
	endfunction

	function automatic step_s makeStep(input logic addr, input regWord_u wr, input logic rnd,
			input logic edges, input int runLen, input regWord_u rd, input logic stb,
			input logic rst, input int t, input int l, input int a, input int d, input int inc);
		step_s s;
		s.wrAddr     = addr;
		s.wrData     = wr;
		s.randDelay  = rnd;
		s.checkEdges = edges;
		s.runLen     = runLen;
		s.expRdata   = rd;
		s.expStable  = stb;
		s.expReset   = rst;
		s.nTick      = t;
		s.nLatch     = l;
		s.nAddr      = a;
		s.nData      = d;
		s.nInc       = inc;
		return s;
	endfunction

	task automatic buildTable();
		steps[0] = makeStep(`REG_CTRL, ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b0, 2,
			ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b1, 0, 0, 0, 0, 0);
		// Clock enable without the oscillator is dropped
		steps[1] = makeStep(`REG_CTRL, ctrlWord(1'b0, 1'b1, 1'b0), 1'b0, 1'b0, 1,
			ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b1, 0, 0, 0, 0, 0);
		// Longer than the reset delay so a timer started without clkEna would show
		steps[2] = makeStep(`REG_CTRL, ctrlWord(1'b1, 1'b0, 1'b0), 1'b0, 1'b0, 10,
			ctrlWord(1'b1, 1'b0, 1'b0), 1'b0, 1'b1, 10, 0, 0, 0, 0);
		steps[3] = makeStep(`REG_CTRL, ctrlWord(1'b1, 1'b1, 1'b0), 1'b0, 1'b0, 4,
			ctrlWord(1'b1, 1'b1, 1'b0), 1'b0, 1'b1, 4, 4, 12, 8, 4);
		steps[4] = makeStep(`REG_CTRL, ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b0, 2,
			ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b1, 0, 0, 0, 0, 0);
		steps[5] = makeStep(`REG_DELAY, delayWord(0), 1'b1, 1'b0, 1,
			delayWord(0), 1'b0, 1'b1, 0, 0, 0, 0, 0);
		steps[6] = makeStep(`REG_CTRL, ctrlWord(1'b1, 1'b1, 1'b0), 1'b0, 1'b1, 10,
			ctrlWord(1'b1, 1'b1, 1'b1), 1'b1, 1'b0, 10, 10, 30, 20, 10);
		steps[7] = makeStep(`REG_CTRL, ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b1, 2,
			ctrlWord(1'b0, 1'b0, 1'b0), 1'b0, 1'b1, 0, 0, 0, 0, 0);
		steps[8] = makeStep(`REG_DELAY, delayWord(0), 1'b1, 1'b0, 1,
			delayWord(0), 1'b0, 1'b1, 0, 0, 0, 0, 0);
		steps[9] = makeStep(`REG_CTRL, ctrlWord(1'b1, 1'b1, 1'b0), 1'b0, 1'b1, 10,
			ctrlWord(1'b1, 1'b1, 1'b1), 1'b1, 1'b0, 10, 10, 30, 20, 10);
	endtask

	task automatic compareWord(input string name, input regWord_u got, input regWord_u exp);
		if (got !== exp) begin
			errWord++;
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic compareBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errBit++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic compareCount(input string name, input int got, input int exp);
		if (got != exp) begin
			errCount++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	// Model of one clock edge e, all decisions on the values before the edge
	task automatic advanceModel(input int e);
		regWord_u w;
		logic     nStable;
		logic     nReset;
		logic     nRun;
		int       nSeen;
		w       = regWdata;
		nStable = mStable;
		nReset  = mReset;
		nRun    = mRun;
		nSeen   = mSeen;
		if (!mOsc) begin
			nStable = 1'b0;
			nReset  = 1'b1;
			nRun    = 1'b0;
			nSeen   = 0;
		end else begin
			if (mTick && mClk && !mRun && !mStable) begin
				nRun  = 1'b1;   // Load tick
				nSeen = 1;
			end else if (mTick && mRun) begin
				nSeen = mSeen + 1;
			end
			if (nRun && nSeen >= mDelay) begin
				nStable = 1'b1;
				nRun    = 1'b0;
			end
			if (mStable && mTick) nReset = 1'b0;   // First tick after stable
		end
		if (nStable !== mStable) mStableEdge = e;
		if (nReset !== mReset) mResetEdge = e;
		mStable = nStable;
		mReset  = nReset;
		mRun    = nRun;
		mSeen   = nSeen;
		if (mOsc) mIdx = (mIdx + 1) % `MCYCLE_LEN;
		mTick = mOsc && (mIdx == 0);
		if (regWrite) begin
			if (regAddr == `REG_CTRL) begin
				mOsc = w.ctrl.oscEna;
				mClk = w.ctrl.clkEna & w.ctrl.oscEna;
			end else begin
				mDelay = int'(w.delay);
			end
		end
	endtask

	// One clock: sample the DUT, note edges, count phases, step the model
	task automatic tick();
		@(posedge clk);
		cycleCnt++;
		smpRdata  = regRdata;
		smpStable = oscStable;
		smpReset  = syncReset;
		if (smpStable !== prevStable) actStableEdge = cycleCnt - 1;
		if (smpReset !== prevReset) actResetEdge = cycleCnt - 1;
		prevStable = smpStable;
		prevReset  = smpReset;
		if (counting) begin
			if (mainTick) cntTick++;
			if (latchPhase) cntLatch++;
			if (addrValid) cntAddr++;
			if (dataPhase) cntData++;
			if (incPhase) cntInc++;
		end
		advanceModel(cycleCnt);
	endtask

	task automatic runStep(input int i);
		step_s s;
		int    d;
		string tag;
		s   = steps[i];
		tag = $sformatf("step %0d", i);
		if (s.randDelay) begin
			d          = int'($urandom_range(6, 1));
			s.wrData   = delayWord(d);
			s.expRdata = delayWord(d);
		end
		regWrite <= 1'b1;
		regAddr  <= s.wrAddr;
		regWdata <= s.wrData;
		tick();   // Write taken here
		regWrite <= 1'b0;
		tick();   // Outputs still from the old enables
		cntTick  = 0;
		cntLatch = 0;
		cntAddr  = 0;
		cntData  = 0;
		cntInc   = 0;
		counting = 1'b1;
		repeat (s.runLen * `MCYCLE_LEN) tick();
		counting = 1'b0;
		compareWord({tag, " regRdata"}, smpRdata, s.expRdata);
		compareBit({tag, " oscStable"}, smpStable, s.expStable);
		compareBit({tag, " syncReset"}, smpReset, s.expReset);
		compareCount({tag, " mainTick count"}, cntTick, s.nTick);
		compareCount({tag, " latchPhase count"}, cntLatch, s.nLatch);
		compareCount({tag, " addrValid count"}, cntAddr, s.nAddr);
		compareCount({tag, " dataPhase count"}, cntData, s.nData);
		compareCount({tag, " incPhase count"}, cntInc, s.nInc);
		if (s.checkEdges) begin
			compareCount({tag, " oscStable edge"}, actStableEdge, mStableEdge);
			compareCount({tag, " syncReset edge"}, actResetEdge, mResetEdge);
			if (s.expStable) begin
				compareCount({tag, " release gap"}, actResetEdge - actStableEdge, `MCYCLE_LEN);
			end
		end
	endtask

	// Watchdog
	initial begin
		@(posedge clk);
		while (timeoutLimit == 0 || wdCycles < timeoutLimit) begin
			@(posedge clk);
			wdCycles++;
		end
		$display("Timeout: no result after %0d clocks", wdCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int total;
		arstN    = 1'b0;
		regWrite = 1'b0;
		regAddr  = `REG_CTRL;
		regWdata = 8'h00;
		counting = 1'b0;
		cycleCnt = 0;
		errWord  = 0;
		errBit   = 0;
		errCount = 0;
		mIdx     = 0;
		mOsc     = 1'b0;
		mClk     = 1'b0;
		mTick    = 1'b0;
		mStable  = 1'b0;
		mReset   = 1'b1;
		mRun     = 1'b0;
		mDelay   = int'(`DELAY_RESET);
		mSeen    = 0;
		mStableEdge   = -1;
		mResetEdge    = -1;
		actStableEdge = -1;
		actResetEdge  = -1;
		void'($urandom(32'he4b7_3503));
		buildTable();
		timeoutLimit = 100;
		for (int i = 0; i < StepCnt; i++) begin
			timeoutLimit += steps[i].runLen * `MCYCLE_LEN;
		end

		repeat (ResetCycles) @(posedge clk);
		arstN <= 1'b1;
		prevStable = oscStable;
		prevReset  = syncReset;

		// Reset values on both registers
		regAddr <= `REG_DELAY;
		tick();
		compareWord("reset regRdata delay", smpRdata, delayWord(`DELAY_RESET));
		regAddr <= `REG_CTRL;
		tick();
		compareWord("reset regRdata ctrl", smpRdata, ctrlWord(1'b0, 1'b0, 1'b0));
		compareBit("reset oscStable", smpStable, 1'b0);
		compareBit("reset syncReset", smpReset, 1'b1);

		for (int i = 0; i < StepCnt; i++) begin
			runStep(i);
		end

		total = errWord + errBit + errCount;
		$display("Errors: word %0d, bit %0d, count %0d, total %0d",
			errWord, errBit, errCount, total);
		if (total == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
